// ==== div_op_pkg.sv ====
package div_op_pkg;

    // Bit 0 set for unsigned, bit 1 for remainder, bit 2 for word forms
    typedef enum logic [2:0] {
        DIV   = 3'b000,
        DIVU  = 3'b001,
        REM   = 3'b010,
        REMU  = 3'b011,
        DIVW  = 3'b100,
        DIVUW = 3'b101,
        REMW  = 3'b110,
        REMUW = 3'b111
    } div_op_e;

    function automatic logic op_is_signed(div_op_e op);
        return op inside {DIV, REM, DIVW, REMW};
    endfunction

    function automatic logic op_is_rem(div_op_e op);
        return op inside {REM, REMU, REMW, REMUW};
    endfunction

    function automatic logic op_is_word(div_op_e op);
        return op inside {DIVW, DIVUW, REMW, REMUW};
    endfunction

endpackage

// ==== div_types_pkg.sv ====
package div_types_pkg;

    import div_op_pkg::*;

    localparam int XLEN             = 64;
    localparam int WORD_W           = 32;
    localparam int DIV_STEPS        = 64;
    localparam int DIV_CNT_W        = $clog2(DIV_STEPS);
    localparam int DIV_TAG_W        = 4;
    localparam int DIV_QUEUE_DEPTH  = 2;
    localparam int DIV_PTR_W        = $clog2(DIV_QUEUE_DEPTH);
    localparam int DIV_FILL_W       = $clog2(DIV_QUEUE_DEPTH + 1);
    localparam int DIV_RESP_CREDITS = 2;
    localparam int DIV_CREDIT_W     = $clog2(DIV_RESP_CREDITS + 1);

    typedef struct packed {
        div_op_e                op;
        logic [DIV_TAG_W-1:0]   tag;
        logic [XLEN-1:0]        dividend;
        logic [XLEN-1:0]        divisor;
    } div_req_t;

    typedef struct packed {
        logic [DIV_TAG_W-1:0]   tag;
        logic [XLEN-1:0]        result;
    } div_resp_t;

    typedef struct packed {
        logic [XLEN-1:0]        dividend;   // Already widened for word forms
        logic [XLEN-1:0]        divisor;
        logic                   is_signed;
        div_op_e                op;
        logic [DIV_TAG_W-1:0]   tag;
    } div_job_t;

    // Keeps the low word, upper bits follow bit 31 only when sext is set
    function automatic logic [XLEN-1:0] widen_word(logic [XLEN-1:0] x, logic sext);
        return {{(XLEN - WORD_W){sext & x[WORD_W-1]}}, x[WORD_W-1:0]};
    endfunction

endpackage

// ==== div_req_queue.sv ====
`timescale 1ns/10ps

module div_req_queue import div_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  div_req_t push_req,
    input  logic     pop,
    output div_req_t head,
    output logic     not_empty,
    output logic     req_credit
);

    div_req_t             mem [DIV_QUEUE_DEPTH];
    logic [DIV_PTR_W-1:0] rd_ptr;
    logic [DIV_PTR_W-1:0] wr_ptr;
    logic [DIV_FILL_W-1:0] count;
    logic                 do_pop;

    function automatic logic [DIV_PTR_W-1:0] ptr_next(logic [DIV_PTR_W-1:0] ptr);
        return (ptr == DIV_PTR_W'(DIV_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign not_empty  = (count != '0);
    assign do_pop     = pop & not_empty;
    assign head       = mem[rd_ptr];
    assign req_credit = do_pop;           // Slot freed, sender may refill it

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_req;       // No full check, credits bound the sender
    end

endmodule

// ==== div_unit_ctrl.sv ====
`timescale 1ns/10ps

module div_unit_ctrl import div_op_pkg::*, div_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     not_empty,
    input  div_req_t head,
    input  logic     core_idle,
    input  logic     resp_sent,
    input  logic     resp_credit,
    output logic     pop,
    output logic     start,
    output div_job_t job
);

    logic [DIV_CREDIT_W-1:0] credit_cnt;
    logic                    in_flight;   // Job launched, response not yet sent
    logic                    credit_ok;
    logic                    sext;

    // A job in flight has already claimed one of the credits
    assign credit_ok = credit_cnt > DIV_CREDIT_W'(in_flight);
    assign pop       = not_empty & core_idle & credit_ok;
    assign start     = pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= DIV_CREDIT_W'(DIV_RESP_CREDITS);
            in_flight  <= 1'b0;
        end else begin
            case ({resp_sent, resp_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            if (start)
                in_flight <= 1'b1;
            else if (resp_sent)
                in_flight <= 1'b0;
        end
    end

    assign sext = op_is_signed(head.op);

    always_comb begin
        job.op        = head.op;
        job.tag       = head.tag;
        job.is_signed = sext;
        if (op_is_word(head.op)) begin
            job.dividend = widen_word(head.dividend, sext);
            job.divisor  = widen_word(head.divisor, sext);
        end else begin
            job.dividend = head.dividend;
            job.divisor  = head.divisor;
        end
    end

endmodule

// ==== div_iter_core.sv ====
`timescale 1ns/10ps

module div_iter_core import div_types_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  div_job_t        job,
    output logic            idle,
    output logic            done,
    output div_job_t        done_job,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);

    logic                   busy;
    logic                   done_r;
    logic [DIV_CNT_W-1:0]   step_cnt;
    logic                   launch;

    logic [2*XLEN-1:0]      part_r;      // Partial remainder over the shifted-out dividend
    logic [XLEN-1:0]        divisor_r;
    logic [XLEN-1:0]        quo_r;
    logic                   dividend_neg;
    logic                   divisor_neg;
    div_job_t               job_r;

    logic                   dividend_sgn;
    logic                   divisor_sgn;
    logic [XLEN-1:0]        dividend_mag;
    logic [XLEN-1:0]        divisor_mag;
    logic [XLEN+1:0]        diff;
    logic                   borrow;
    logic [XLEN-1:0]        rem_mag;

    assign idle   = ~busy & ~done_r;
    assign launch = start & idle;

    assign dividend_sgn = job.is_signed & job.dividend[XLEN-1];
    assign divisor_sgn  = job.is_signed & job.divisor[XLEN-1];
    assign dividend_mag = dividend_sgn ? -job.dividend : job.dividend;
    assign divisor_mag  = divisor_sgn  ? -job.divisor  : job.divisor;

    // Trial subtraction on the top XLEN+1 bits, borrow means restore
    assign diff   = {1'b0, part_r[2*XLEN-1:XLEN-1]} - {2'b00, divisor_r};
    assign borrow = diff[XLEN+1];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            done_r   <= 1'b0;
            step_cnt <= '0;
        end else begin
            done_r <= 1'b0;
            if (launch) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == DIV_CNT_W'(DIV_STEPS - 1)) begin
                    busy   <= 1'b0;
                    done_r <= 1'b1;   // Last step lands on this edge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            part_r       <= {{XLEN{1'b0}}, dividend_mag};
            divisor_r    <= divisor_mag;
            quo_r        <= '0;
            dividend_neg <= dividend_sgn;
            divisor_neg  <= divisor_sgn;
            job_r        <= job;
        end else if (busy) begin
            if (borrow)
                part_r <= {part_r[2*XLEN-2:0], 1'b0};
            else
                part_r <= {diff[XLEN-1:0], part_r[XLEN-2:0], 1'b0};
            quo_r <= {quo_r[XLEN-2:0], ~borrow};
        end
    end

    assign rem_mag   = part_r[2*XLEN-1:XLEN];
    assign quotient  = (dividend_neg ^ divisor_neg) ? -quo_r : quo_r;
    assign remainder = dividend_neg ? -rem_mag : rem_mag;  // Takes the dividend's sign
    assign done      = done_r;
    assign done_job  = job_r;

endmodule

// ==== div_result_fix.sv ====
`timescale 1ns/10ps

module div_result_fix import div_op_pkg::*, div_types_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            done,
    input  div_job_t        done_job,
    input  logic [XLEN-1:0] quotient,
    input  logic [XLEN-1:0] remainder,
    output logic            resp_valid,
    output div_resp_t       resp
);

    logic            is_rem;
    logic            div_by_zero;
    logic [XLEN-1:0] chosen;
    logic [XLEN-1:0] fixed;

    assign is_rem      = op_is_rem(done_job.op);
    assign div_by_zero = (done_job.divisor == '0);

    always_comb begin
        if (div_by_zero)
            chosen = is_rem ? done_job.dividend : '1;   // RISC-V divide by zero
        else
            chosen = is_rem ? remainder : quotient;
    end

    // Word results are always sign-extended, even for the unsigned forms
    assign fixed = op_is_word(done_job.op) ? widen_word(chosen, 1'b1) : chosen;

    always_ff @(posedge clk) begin
        if (reset)
            resp_valid <= 1'b0;
        else
            resp_valid <= done;
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp.tag    <= done_job.tag;
            resp.result <= fixed;
        end
    end

endmodule

// ==== div_unit.sv ====
`timescale 1ns/10ps

module div_unit import div_types_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      req_valid,
    input  div_req_t  req,
    output logic      req_credit,
    output logic      resp_valid,
    output div_resp_t resp,
    input  logic      resp_credit
);

    div_req_t        head;
    logic            not_empty;
    logic            pop;
    logic            start;
    div_job_t        job;
    logic            core_idle;
    logic            done;
    div_job_t        done_job;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;

    div_req_queue i_div_req_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (req_valid),
        .push_req   (req),
        .pop        (pop),
        .head       (head),
        .not_empty  (not_empty),
        .req_credit (req_credit)
    );

    div_unit_ctrl i_div_unit_ctrl (
        .clk         (clk),
        .reset       (reset),
        .not_empty   (not_empty),
        .head        (head),
        .core_idle   (core_idle),
        .resp_sent   (resp_valid),     // Each response spends an output credit
        .resp_credit (resp_credit),
        .pop         (pop),
        .start       (start),
        .job         (job)
    );

    div_iter_core i_div_iter_core (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .job       (job),
        .idle      (core_idle),
        .done      (done),
        .done_job  (done_job),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_result_fix i_div_result_fix (
        .clk        (clk),
        .reset      (reset),
        .done       (done),
        .done_job   (done_job),
        .quotient   (quotient),
        .remainder  (remainder),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

// ==== div_unit_assertions.sv ====
`timescale 1ns/10ps

module div_unit_assertions import div_types_pkg::*; (
    input logic clk,
    input logic reset,
    input logic start,
    input logic idle,
    input logic done
);

    localparam int DONE_DELAY = DIV_STEPS + 1;

    start_needs_idle: assert property (@(posedge clk) disable iff (reset) start |-> idle)
        else $error("start raised while the divider core was busy");

    done_after_start: assert property (@(posedge clk) disable iff (reset)
                                       start |-> ##DONE_DELAY done)
        else $error("done did not follow start after the fixed latency");

    idle_after_reset: assert property (@(posedge clk) reset |=> idle)
        else $error("divider core not idle after reset");

endmodule

// ==== tb_div_unit.sv ====
`timescale 1ns/10ps

module tb_div_unit import div_op_pkg::*, div_types_pkg::*; ();

    localparam int HALF_PERIOD    = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 5;
    localparam int JOB_CYCLES     = 66;
    localparam int MAX_JOBS       = 300;
    localparam int TIMEOUT_CYCLES = MAX_JOBS * JOB_CYCLES * 2 + 400;   // 40000

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 req_valid;
    div_req_t             req;
    logic                 req_credit;
    logic                 resp_valid;
    div_resp_t            resp;
    logic                 resp_credit = 1'b0;

    div_resp_t            exp_q[$];
    int                   sent_count = 0;
    int                   resp_seen = 0;
    int                   req_credit_seen = 0;
    int                   credits_returned = 0;
    int                   cycle_cnt = 0;
    logic                 hold_credits = 1'b0;
    logic [DIV_TAG_W-1:0] next_tag = '0;
    logic [31:0]          lfsr = 32'ha56c47d9;

    div_unit i_div_unit (.*);

    bind div_iter_core div_unit_assertions i_div_unit_assertions (.*);

    initial begin
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_resp(div_resp_t actual, div_resp_t expected);
        if (actual.tag !== expected.tag)
            report_failure($sformatf("Error at %0d ns: resp.tag = 0x%h, expected 0x%h",
                                     $time, actual.tag, expected.tag));
        if (actual.result !== expected.result)
            report_failure($sformatf("Error at %0d ns: resp.result = 0x%h, expected 0x%h",
                                     $time, actual.result, expected.result));
    endtask

    function automatic logic [XLEN-1:0] ref_div(div_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0]        r;
        sa = a;
        sb = b;
        if (op_is_word(op)) begin   // Word forms see only the low 32 bits
            sa = op_is_signed(op) ? {{32{a[31]}}, a[31:0]} : {32'd0, a[31:0]};
            sb = op_is_signed(op) ? {{32{b[31]}}, b[31:0]} : {32'd0, b[31:0]};
        end
        if (sb == 0)
            r = op_is_rem(op) ? sa : '1;
        else if (op_is_signed(op) && sb == -1)
            r = op_is_rem(op) ? '0 : -sa;   // Most negative dividend wraps to itself
        else if (op_is_signed(op))
            r = op_is_rem(op) ? sa % sb : sa / sb;
        else
            r = op_is_rem(op) ? $unsigned(sa) % $unsigned(sb) : $unsigned(sa) / $unsigned(sb);
        return op_is_word(op) ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    function automatic logic [XLEN-1:0] rand_bits(int n);
        logic [XLEN-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[XLEN-2:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic int credits_left();
        return DIV_QUEUE_DEPTH + req_credit_seen - sent_count;
    endfunction

    // Credit and response monitor on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (req_credit)
                req_credit_seen++;
            if (resp_valid) begin
                if (resp_seen >= exp_q.size())
                    report_failure("resp_valid pulsed with no request outstanding");
                compare_resp(resp, exp_q[resp_seen]);
                resp_seen++;
            end
        end
    end

    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (!reset && !hold_credits && credits_returned < resp_seen) begin
            resp_credit = 1'b1;
            credits_returned++;
        end else begin
            resp_credit = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            report_failure("Timeout: the run exceeded its cycle limit without finishing");
    end

    task automatic wait_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send_req(div_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        div_resp_t expected;
        while (credits_left() == 0)
            wait_cycle();
        expected.tag    = next_tag;
        expected.result = ref_div(op, a, b);
        exp_q.push_back(expected);
        req_valid    = 1'b1;
        req.op       = op;
        req.tag      = next_tag;
        req.dividend = a;
        req.divisor  = b;
        next_tag     = next_tag + 1'b1;
        sent_count++;
        wait_cycle();
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (resp_seen < sent_count || credits_returned < resp_seen)
            wait_cycle();
    endtask

    task automatic test_idle_after_reset();
        repeat (10)
            wait_cycle();
        if (req_credit_seen != 0 || resp_seen != 0)
            report_failure("req_credit or resp_valid pulsed before any request was sent");
    endtask

    task automatic test_basic_ops();
        logic [XLEN-1:0] a [8];
        logic [XLEN-1:0] b [8];
        a = '{64'd100, -64'sd100, 64'd100, -64'sd100, 64'd5, -64'sd5,
              64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210};
        b = '{64'd7, 64'd7, -64'sd7, -64'sd7, 64'd9, 64'd9, 64'h1234, 64'hffff_ffff};
        for (int o = 0; o < 8; o++)
            for (int i = 0; i < 8; i++)
                send_req(div_op_e'(o[2:0]), a[i], b[i]);
        wait_drain();
    endtask

    task automatic test_edge_cases();
        for (int o = 0; o < 8; o++) begin
            send_req(div_op_e'(o[2:0]), 64'hdead_beef_8765_4321, '0);
            send_req(div_op_e'(o[2:0]), 64'h0000_0001_0000_0064, 64'hffff_ffff_0000_0000);
            send_req(div_op_e'(o[2:0]), 64'hffff_0000_ffff_ff9c, 64'h1234_0000_0000_0007);
        end
        send_req(DIV, 64'h8000_0000_0000_0000, '1);
        send_req(REM, 64'h8000_0000_0000_0000, '1);
        send_req(DIVW, 64'h1234_5678_8000_0000, '1);
        send_req(REMW, 64'h0000_0000_8000_0000, 64'hffff_0000_ffff_ffff);
        wait_drain();
    endtask

    task automatic test_random(int jobs);
        logic [XLEN-1:0] sel;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int j = 0; j < jobs; j++) begin
            sel = rand_bits(3);
            a   = rand_bits(64);
            case (rand_bits(2))
                64'd0:   b = rand_bits(64);
                64'd1:   b = rand_bits(20);
                64'd2:   b = -rand_bits(12);
                default: b = rand_bits(2);   // Includes zero
            endcase
            send_req(div_op_e'(sel[2:0]), a, b);
        end
        wait_drain();
    endtask

    task automatic test_credit_hold();
        int base;
        int credit_mark;
        base         = resp_seen;
        hold_credits = 1'b1;
        for (int i = 0; i < 4; i++)
            send_req(div_op_e'(i[2:0]), 64'd1000 + 64'(i), 64'd3);
        while (resp_seen < base + 2)
            wait_cycle();
        credit_mark = req_credit_seen;
        repeat (3 * JOB_CYCLES)
            wait_cycle();
        if (resp_seen != base + 2)
            report_failure("resp_valid appeared while the output credits were withheld");
        if (req_credit_seen != credit_mark || credits_left() != 0)
            report_failure("req_credit pulsed although the request queue should be full");
        hold_credits = 1'b0;
        send_req(REMW, 64'hffff_ffff_ffff_fff9, 64'd2);
        wait_drain();
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (RESET_CYCLES)
            @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        test_idle_after_reset();
        test_basic_ops();
        test_edge_cases();
        test_random(150);
        test_credit_hold();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== all.f ====
div_op_pkg.sv
div_types_pkg.sv
div_req_queue.sv
div_unit_ctrl.sv
div_iter_core.sv
div_result_fix.sv
div_unit.sv
div_unit_assertions.sv
tb_div_unit.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_div_unit \
    -f all.f -o sim_div_unit || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_div_unit > sim.log 2>&1
grep -q "=== PASS ===" sim.log && echo "Simulation passed" || { cat sim.log; exit 1; }
